//--- common/gfx_consts.svh
// graphics constants
// framebuffer geometry, colour index width and display timing
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

`define GFX_FB_WIDTH  32    // pixels per row
`define GFX_FB_HEIGHT 18    // rows
`define GFX_CORDW     8     // signed coordinate width
`define GFX_CIDXW     4     // colour index width

`define GFX_H_ACTIVE  32
`define GFX_H_FRONT   2
`define GFX_H_SYNC    4
`define GFX_H_BACK    2
`define GFX_H_TOTAL   (`GFX_H_ACTIVE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK)

`define GFX_V_ACTIVE  18
`define GFX_V_FRONT   1
`define GFX_V_SYNC    2
`define GFX_V_BACK    1
`define GFX_V_TOTAL   (`GFX_V_ACTIVE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK)

`endif

//--- common/gfx_pkg.sv
// drawing types
// coordinates, vertices, triangle commands and pixel writes
`include "gfx_consts.svh"

package gfx_pkg;

    typedef logic signed [`GFX_CORDW-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    typedef struct packed {
        vertex_t                v0;
        vertex_t                v1;
        vertex_t                v2;
        logic [`GFX_CIDXW-1:0] cidx;    // fill colour
    } triangle_t;

    typedef struct packed {
        coord_t                 x;
        coord_t                 y;
        logic [`GFX_CIDXW-1:0] cidx;
    } pix_write_t;

    typedef enum logic [2:0] {
        IDLE,
        SORT,
        INIT_EDGES,
        SPAN,
        NEXT_LINE,
        DONE
    } fill_state_e;

endpackage

//--- common/dvi_pkg.sv
// video output types
// sync flags, rgb pixels and tmds symbols
package dvi_pkg;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;       // active picture
    } video_ctrl_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef logic [9:0] tmds_word_t;

    typedef struct packed {
        tmds_word_t ch0;    // blue plus syncs
        tmds_word_t ch1;    // green
        tmds_word_t ch2;    // red
    } tmds_bus_t;

    typedef enum logic {
        CTRL,
        VIDEO
    } enc_mode_e;

endpackage

//--- src/display_timings.sv
// display timing generator
// screen position, active high syncs and data enable
`timescale 1ns/10ps
`include "gfx_consts.svh"

module display_timings (
    input  logic                 clk_100m,
    input  logic                 arst_n,
    output gfx_pkg::coord_t      sx,
    output gfx_pkg::coord_t      sy,
    output dvi_pkg::video_ctrl_t ctrl,
    output logic                 frame
);

    localparam int H_TOTAL   = `GFX_H_TOTAL;
    localparam int V_TOTAL   = `GFX_V_TOTAL;
    localparam int HS_START  = `GFX_H_ACTIVE + `GFX_H_FRONT;
    localparam int HS_END    = HS_START + `GFX_H_SYNC;
    localparam int VS_START  = `GFX_V_ACTIVE + `GFX_V_FRONT;
    localparam int VS_END    = VS_START + `GFX_V_SYNC;

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == H_TOTAL - 1);
    assign frame_end = line_end && (sy == V_TOTAL - 1);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= '0;
            sy    <= '0;
            frame <= 1'b0;
        end else begin
            frame <= frame_end;     // high together with position 0,0
            if (line_end) begin
                sx <= '0;
                sy <= frame_end ? '0 : sy + 1'b1;
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    always_comb begin
        ctrl.hsync = (sx >= HS_START) && (sx < HS_END);
        ctrl.vsync = (sy >= VS_START) && (sy < VS_END);
        ctrl.de    = (sx < `GFX_H_ACTIVE) && (sy < `GFX_V_ACTIVE);
    end

    a_sx_range: assert property (@(posedge clk_100m) disable iff (!arst_n)
        (sx >= 0) && (sx < H_TOTAL));

endmodule

//--- draw/draw_line.sv
// bresenham line walker
// moves one pixel from p0 towards p1 on each advance request
`timescale 1ns/10ps
`include "gfx_consts.svh"

module draw_line (
    input  logic             clk_100m,
    input  logic             arst_n,
    input  logic             start,
    input  logic             adv,
    input  gfx_pkg::vertex_t p0,
    input  gfx_pkg::vertex_t p1,
    output gfx_pkg::vertex_t pos,
    output logic             last
);

    localparam int EW = `GFX_CORDW + 3;    // room for 2*err
    localparam gfx_pkg::coord_t ONE = 1;

    logic signed [EW-1:0] dx;       // +|x1-x0|
    logic signed [EW-1:0] dy;       // -|y1-y0|
    logic signed [EW-1:0] err;
    logic signed [EW-1:0] e2;
    logic signed [EW-1:0] adx;
    logic signed [EW-1:0] ady;
    logic signed [EW-1:0] err_n;
    logic                 x_dec;
    logic                 y_dec;
    gfx_pkg::vertex_t     p_end;
    gfx_pkg::vertex_t     pos_n;

    assign last = (pos == p_end);
    assign e2   = err <<< 1;

    always_comb begin
        adx = EW'(p1.x) - EW'(p0.x);
        ady = EW'(p1.y) - EW'(p0.y);
        if (adx < 0) begin
            adx = -adx;
        end
        if (ady < 0) begin
            ady = -ady;
        end
    end

    // one bresenham step
    always_comb begin
        err_n = err;
        pos_n = pos;
        if (e2 >= dy) begin
            err_n   = err_n + dy;
            pos_n.x = x_dec ? pos.x - ONE : pos.x + ONE;
        end
        if (e2 <= dx) begin
            err_n   = err_n + dx;
            pos_n.y = y_dec ? pos.y - ONE : pos.y + ONE;
        end
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            pos   <= '0;
            p_end <= '0;
            dx    <= '0;
            dy    <= '0;
            err   <= '0;
            x_dec <= 1'b0;
            y_dec <= 1'b0;
        end else if (start) begin
            pos   <= p0;
            p_end <= p1;
            dx    <= adx;
            dy    <= -ady;
            err   <= adx - ady;
            x_dec <= (p1.x < p0.x);
            y_dec <= (p1.y < p0.y);
        end else if (adv && !last) begin
            pos <= pos_n;
            err <= err_n;
        end
    end

endmodule

//--- draw/draw_triangle_fill.sv
// filled triangle engine
// traces the long edge and both short edges, then writes one span per row
`timescale 1ns/10ps
`include "gfx_consts.svh"

module draw_triangle_fill (
    input  logic                clk_100m,
    input  logic                arst_n,
    input  logic                start,
    input  gfx_pkg::triangle_t  cmd,
    output logic                busy,
    output logic                done,
    output logic                wr_en,
    output gfx_pkg::pix_write_t wr
);

    localparam gfx_pkg::coord_t ONE   = 1;
    localparam gfx_pkg::coord_t C_MAX = (2 ** (`GFX_CORDW - 1)) - 1;
    localparam gfx_pkg::coord_t C_MIN = -(2 ** (`GFX_CORDW - 1));

    gfx_pkg::fill_state_e  state;
    gfx_pkg::vertex_t      s0, s1, s2;          // sorted by y after SORT
    gfx_pkg::vertex_t      srt0, srt1, srt2;
    logic [`GFX_CIDXW-1:0] cidx;
    gfx_pkg::coord_t       y, x, x_end;
    gfx_pkg::coord_t       xmin, xmax, xmin_n, xmax_n;
    logic                  half2;               // short edge now on s1 -> s2

    logic             a_start, a_adv, a_last, a_on, a_done;
    logic             b_start, b_adv, b_last, b_on, b_done, b_reload;
    gfx_pkg::vertex_t a_pos, b_pos, b_p0, b_p1;
    logic             walking;

    // three compare-swaps on y
    always_comb begin
        gfx_pkg::vertex_t t;
        t    = s0;
        srt0 = s0;
        srt1 = s1;
        srt2 = s2;
        if (srt0.y > srt1.y) begin
            t    = srt0;
            srt0 = srt1;
            srt1 = t;
        end
        if (srt1.y > srt2.y) begin
            t    = srt1;
            srt1 = srt2;
            srt2 = t;
        end
        if (srt0.y > srt1.y) begin
            t    = srt0;
            srt0 = srt1;
            srt1 = t;
        end
    end

    assign walking  = (state == gfx_pkg::NEXT_LINE);
    assign a_on     = (a_pos.y == y);
    assign b_on     = (b_pos.y == y);
    assign a_done   = !a_on || a_last;
    assign b_reload = walking && !half2 && b_on && b_last;
    assign b_done   = !b_on || (b_last && half2);
    assign a_start  = (state == gfx_pkg::INIT_EDGES);
    assign b_start  = (state == gfx_pkg::INIT_EDGES) || b_reload;
    assign a_adv    = walking && a_on && !a_last;
    assign b_adv    = walking && b_on && !b_last;
    assign b_p0     = (half2 || b_reload) ? s1 : s0;
    assign b_p1     = (half2 || b_reload) ? s2 : s1;

    draw_line i_edge_long (
        .clk_100m, .arst_n,
        .start(a_start), .adv(a_adv),
        .p0(s0), .p1(s2),
        .pos(a_pos), .last(a_last)
    );

    draw_line i_edge_short (
        .clk_100m, .arst_n,
        .start(b_start), .adv(b_adv),
        .p0(b_p0), .p1(b_p1),
        .pos(b_pos), .last(b_last)
    );

    // span limits including the edge pixels seen this cycle
    always_comb begin
        xmin_n = xmin;
        xmax_n = xmax;
        if (a_on && a_pos.x < xmin_n) xmin_n = a_pos.x;
        if (a_on && a_pos.x > xmax_n) xmax_n = a_pos.x;
        if (b_on && b_pos.x < xmin_n) xmin_n = b_pos.x;
        if (b_on && b_pos.x > xmax_n) xmax_n = b_pos.x;
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state <= gfx_pkg::IDLE;
            s0    <= '0;
            s1    <= '0;
            s2    <= '0;
            cidx  <= '0;
            y     <= '0;
            x     <= '0;
            x_end <= '0;
            xmin  <= C_MAX;
            xmax  <= C_MIN;
            half2 <= 1'b0;
        end else begin
            case (state)
                gfx_pkg::IDLE: if (start) begin
                    s0    <= cmd.v0;
                    s1    <= cmd.v1;
                    s2    <= cmd.v2;
                    cidx  <= cmd.cidx;
                    state <= gfx_pkg::SORT;
                end
                gfx_pkg::SORT: begin
                    s0    <= srt0;
                    s1    <= srt1;
                    s2    <= srt2;
                    half2 <= 1'b0;              // short walker starts on s0 -> s1
                    state <= gfx_pkg::INIT_EDGES;
                end
                gfx_pkg::INIT_EDGES: begin      // edge walkers load here
                    y     <= s0.y;
                    xmin  <= C_MAX;
                    xmax  <= C_MIN;
                    state <= gfx_pkg::NEXT_LINE;
                end
                gfx_pkg::NEXT_LINE: begin
                    xmin <= xmin_n;
                    xmax <= xmax_n;
                    if (b_reload) half2 <= 1'b1;
                    if (a_done && b_done) begin
                        x     <= xmin_n;
                        x_end <= xmax_n;
                        state <= gfx_pkg::SPAN;
                    end
                end
                gfx_pkg::SPAN: begin
                    if (x != x_end) begin
                        x <= x + ONE;
                    end else if (y == s2.y) begin
                        state <= gfx_pkg::DONE;
                    end else begin
                        y     <= y + ONE;
                        xmin  <= C_MAX;
                        xmax  <= C_MIN;
                        state <= gfx_pkg::NEXT_LINE;
                    end
                end
                default: state <= gfx_pkg::IDLE;    // DONE
            endcase
        end
    end

    always_comb begin
        busy    = (state != gfx_pkg::IDLE);
        done    = (state == gfx_pkg::DONE);
        wr_en   = (state == gfx_pkg::SPAN);
        wr.x    = x;
        wr.y    = y;
        wr.cidx = cidx;
    end

    a_start_no_done: assert property (@(posedge clk_100m) disable iff (!arst_n)
        (start && !busy) |-> !done ##1 (busy && !done));

    a_write_in_fill: assert property (@(posedge clk_100m) disable iff (!arst_n)
        wr_en |=> busy);

endmodule

//--- src/framebuffer.sv
// framebuffer with colour index memory and palette lookup
// index read in the first cycle, palette in the second, syncs delayed to match
`timescale 1ns/10ps
`include "gfx_consts.svh"

module framebuffer (
    input  logic                 clk_100m,
    input  logic                 arst_n,
    input  logic                 wr_en,
    input  gfx_pkg::pix_write_t  wr,
    input  gfx_pkg::coord_t      sx,
    input  gfx_pkg::coord_t      sy,
    input  dvi_pkg::video_ctrl_t ctrl_in,
    output dvi_pkg::rgb_t        rgb,
    output dvi_pkg::video_ctrl_t ctrl_out
);

    localparam int DEPTH = `GFX_FB_WIDTH * `GFX_FB_HEIGHT;
    localparam int AW    = $clog2(DEPTH);

    // 16 colour palette, entry 0 black
    localparam logic [23:0] PALETTE [2**`GFX_CIDXW] = '{
        24'h000000, 24'h1D2B53, 24'h7E2553, 24'h008751,
        24'hAB5236, 24'h5F574F, 24'hC2C3C7, 24'hFFF1E8,
        24'hFF004D, 24'hFFA300, 24'hFFEC27, 24'h00E436,
        24'h29ADFF, 24'h83769C, 24'hFF77A8, 24'hFFCCAA
    };

    logic [`GFX_CIDXW-1:0] mem [DEPTH];
    logic [`GFX_CIDXW-1:0] idx;
    logic [AW-1:0]         waddr;
    logic [AW-1:0]         raddr;
    logic                  wr_ok;
    dvi_pkg::video_ctrl_t  ctrl_d1;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        wr_ok = wr_en && (wr.x >= 0) && (wr.x < `GFX_FB_WIDTH)
                      && (wr.y >= 0) && (wr.y < `GFX_FB_HEIGHT);   // clip
        waddr = AW'(int'(wr.y) * `GFX_FB_WIDTH + int'(wr.x));
        raddr = AW'(int'(sy) * `GFX_FB_WIDTH + int'(sx));
    end

    always_ff @(posedge clk_100m) begin
        if (wr_ok) begin
            mem[waddr] <= wr.cidx;
        end
        if (ctrl_in.de) begin
            idx <= mem[raddr];
        end
        rgb <= ctrl_d1.de ? dvi_pkg::rgb_t'(PALETTE[idx]) : '0;   // black in blanking
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_d1  <= '0;
            ctrl_out <= '0;
        end else begin
            ctrl_d1  <= ctrl_in;
            ctrl_out <= ctrl_d1;
        end
    end

endmodule

//--- dvi/tmds_encoder.sv
// dvi tmds encoder
// transition minimised 8b/10b data symbols with dc balance, fixed control symbols
`timescale 1ns/10ps

module tmds_encoder (
    input  logic                clk_100m,
    input  logic                arst_n,
    input  logic [7:0]          data,
    input  logic [1:0]          ctrl,       // {c1, c0}
    input  logic                de,
    output dvi_pkg::tmds_word_t sym
);

    localparam dvi_pkg::tmds_word_t CTRL_00 = 10'b1101010100;
    localparam dvi_pkg::tmds_word_t CTRL_01 = 10'b0010101011;
    localparam dvi_pkg::tmds_word_t CTRL_10 = 10'b0101010100;
    localparam dvi_pkg::tmds_word_t CTRL_11 = 10'b1010101011;

    dvi_pkg::enc_mode_e mode;
    logic [3:0]         n1_data;
    logic [3:0]         n1_qm;
    logic               use_xnor;
    logic [8:0]         q_m;
    logic signed [4:0]  balance;    // (ones - zeros) / 2 of q_m
    logic signed [4:0]  bias;       // running disparity, same units

    assign mode = de ? dvi_pkg::VIDEO : dvi_pkg::CTRL;

    always_comb begin
        n1_data  = 4'($countones(data));
        use_xnor = (n1_data > 4'd4) || (n1_data == 4'd4 && !data[0]);
        q_m[0]   = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8]  = ~use_xnor;
        n1_qm   = 4'($countones(q_m[7:0]));
        balance = $signed({1'b0, n1_qm}) - 5'sd4;
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            sym  <= CTRL_00;
            bias <= '0;
        end else if (mode == dvi_pkg::CTRL) begin
            bias <= '0;                     // disparity restarts each blanking
            case (ctrl)
                2'b00:   sym <= CTRL_00;
                2'b01:   sym <= CTRL_01;
                2'b10:   sym <= CTRL_10;
                default: sym <= CTRL_11;
            endcase
        end else if (bias == 0 || balance == 0) begin
            if (q_m[8]) begin
                sym  <= {2'b01, q_m[7:0]};
                bias <= bias + balance;
            end else begin
                sym  <= {2'b10, ~q_m[7:0]};
                bias <= bias - balance;
            end
        end else if (bias[4] == balance[4]) begin  // same sign, invert
            sym  <= {1'b1, q_m[8], ~q_m[7:0]};
            bias <= bias + $signed({4'b0, q_m[8]}) - balance;
        end else begin
            sym  <= {1'b0, q_m[8], q_m[7:0]};
            bias <= bias - $signed({4'b0, ~q_m[8]}) + balance;
        end
    end

    a_bias_bound: assert property (@(posedge clk_100m) disable iff (!arst_n)
        (mode == dvi_pkg::VIDEO) |=> (bias >= -8) && (bias <= 8));

endmodule

//--- src/triangle_gfx_top.sv
// triangle graphics top level
// fill engine and framebuffer feeding display timing and three tmds encoders
`timescale 1ns/10ps

module triangle_gfx_top (
    input  logic               clk_100m,
    input  logic               arst_n,
    input  logic               draw_start,
    input  gfx_pkg::triangle_t cmd,
    output logic               draw_busy,
    output logic               draw_done,
    output logic               frame,
    output dvi_pkg::tmds_bus_t tmds
);

    gfx_pkg::pix_write_t  wr;
    logic                 wr_en;
    gfx_pkg::coord_t      sx, sy;
    dvi_pkg::video_ctrl_t ctrl;         // at counter position
    dvi_pkg::video_ctrl_t ctrl_px;      // aligned with rgb
    dvi_pkg::rgb_t        rgb;
    logic [7:0]           chan_data [3];
    logic [1:0]           chan_ctrl [3];
    dvi_pkg::tmds_word_t  chan_sym  [3];

    draw_triangle_fill i_draw_triangle_fill (
        .clk_100m, .arst_n,
        .start(draw_start), .cmd,
        .busy(draw_busy), .done(draw_done),
        .wr_en, .wr
    );

    display_timings i_display_timings (
        .clk_100m, .arst_n,
        .sx, .sy, .ctrl, .frame
    );

    framebuffer i_framebuffer (
        .clk_100m, .arst_n,
        .wr_en, .wr,
        .sx, .sy, .ctrl_in(ctrl),
        .rgb, .ctrl_out(ctrl_px)
    );

    always_comb begin
        chan_data[0] = rgb.blue;
        chan_data[1] = rgb.green;
        chan_data[2] = rgb.red;
        chan_ctrl[0] = {ctrl_px.vsync, ctrl_px.hsync};  // syncs ride on blue
        chan_ctrl[1] = 2'b00;
        chan_ctrl[2] = 2'b00;
        tmds.ch0     = chan_sym[0];
        tmds.ch1     = chan_sym[1];
        tmds.ch2     = chan_sym[2];
    end

    for (genvar ch = 0; ch < 3; ch++) begin : g_enc
        tmds_encoder i_tmds_encoder (
            .clk_100m, .arst_n,
            .data(chan_data[ch]), .ctrl(chan_ctrl[ch]), .de(ctrl_px.de),
            .sym(chan_sym[ch])
        );
    end

endmodule

//--- tests/tb_triangle_gfx.sv
// testbench for the triangle graphics top level
// reads triangle commands and expected pixels, decodes the tmds output and checks it
`timescale 1ns/10ps
`include "gfx_consts.svh"

module tb_triangle_gfx;

    localparam int LINE_CLKS  = `GFX_H_TOTAL;
    localparam int FRAME_CLKS = `GFX_H_TOTAL * `GFX_V_TOTAL;
    localparam int LATENCY    = 3;                      // counter to symbol
    localparam logic [9:0] SYM_00 = 10'b1101010100;
    localparam logic [9:0] SYM_01 = 10'b0010101011;
    localparam logic [9:0] SYM_10 = 10'b0101010100;
    localparam logic [9:0] SYM_11 = 10'b1010101011;

    logic               clk_100m;
    logic               arst_n;
    logic               draw_start;
    gfx_pkg::triangle_t cmd;
    logic               draw_busy;
    logic               draw_done;
    logic               frame;
    dvi_pkg::tmds_bus_t tmds;

    gfx_pkg::triangle_t cmd_q[$];
    int                 chk_x[$];
    int                 chk_y[$];
    logic [23:0]        chk_rgb[$];
    logic [23:0]        cap [`GFX_FB_HEIGHT][`GFX_FB_WIDTH];
    bit                 loaded;
    bit                 capturing;
    bit                 locked;
    int                 err_count;
    int                 done_count;
    int                 seed;
    int                 row;
    int                 col;
    int                 pos_cnt;
    bit                 prev_video;
    int                 disp [3];

    triangle_gfx_top i_triangle_gfx_top (
        .clk_100m, .arst_n,
        .draw_start, .cmd,
        .draw_busy, .draw_done,
        .frame, .tmds
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    task automatic stop_run(input string what);
        err_count++;
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        stop_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    // standard dvi decode of a data symbol
    function automatic logic [7:0] tmds_decode(input logic [9:0] s);
        logic [7:0] q;
        logic [7:0] d;
        q    = s[9] ? ~s[7:0] : s[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return d;
    endfunction

    function automatic logic [9:0] ctrl_symbol(input logic c1, input logic c0);
        case ({c1, c0})
            2'b00:   return SYM_00;
            2'b01:   return SYM_01;
            2'b10:   return SYM_10;
            default: return SYM_11;
        endcase
    endfunction

    function automatic bit is_ctrl(input logic [9:0] s);
        return (s == SYM_00) || (s == SYM_01) || (s == SYM_10) || (s == SYM_11);
    endfunction

    task automatic load_file();
        int    fd;
        string line;
        string kind;
        int    v [7];
        int    px;
        int    py;
        logic [23:0] rgb;
        gfx_pkg::triangle_t t;
        fd = $fopen("tests/triangle_input.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open tests/triangle_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s", kind));
            if (kind == "T") begin
                void'($sscanf(line, "T %d %d %d %d %d %d %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6]));
                t.v0.x = v[0];
                t.v0.y = v[1];
                t.v1.x = v[2];
                t.v1.y = v[3];
                t.v2.x = v[4];
                t.v2.y = v[5];
                t.cidx = v[6];
                cmd_q.push_back(t);
            end else if (kind == "P") begin
                void'($sscanf(line, "P %d %d %h", px, py, rgb));
                chk_x.push_back(px);
                chk_y.push_back(py);
                chk_rgb.push_back(rgb);
            end
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    // issue one command plus an ignored second start while busy
    task automatic run_triangle(input gfx_pkg::triangle_t t, input int n);
        int dones_before;
        int gap;
        dones_before = done_count;
        draw_start = 1'b1;
        cmd        = t;
        @(negedge clk_100m);
        draw_start = 1'b0;
        assert (draw_busy === 1'b1) else value_error($sformatf("busy cmd %0d", n), 1, draw_busy);
        gap = 2 + ($random(seed) & 3);
        repeat (gap) @(negedge clk_100m);
        draw_start = 1'b1;                  // must be ignored
        @(negedge clk_100m);
        draw_start = 1'b0;
        while (draw_busy) @(negedge clk_100m);
        assert (done_count - dones_before == 1)
            else value_error($sformatf("done pulses cmd %0d", n), 1, done_count - dones_before);
    endtask

    // output monitor with position tracking, sync and disparity checks
    always @(negedge clk_100m) begin
        int    p;
        int    hx;
        int    vy;
        bit    video;
        bit    exp_de;
        logic [9:0] exp_sym;
        if (arst_n) begin
            if (draw_done) done_count++;
            video = !is_ctrl(tmds.ch0);
            if (locked) begin
                assert (frame == (pos_cnt == FRAME_CLKS - 1))
                    else stop_run("frame pulse does not repeat every frame length");
                // pos_cnt still holds the previous counter position here
                p  = (pos_cnt + 1 + FRAME_CLKS - LATENCY) % FRAME_CLKS;
                hx = p % LINE_CLKS;
                vy = p / LINE_CLKS;
                exp_de = (hx < `GFX_H_ACTIVE) && (vy < `GFX_V_ACTIVE);
                exp_sym = ctrl_symbol(
                    (vy >= 19) && (vy < 21),
                    (hx >= 34) && (hx < 38));
                if (exp_de) begin
                    assert (video) else value_error("ch0 video", 1, tmds.ch0);
                end else begin
                    assert (tmds.ch0 == exp_sym) else value_error("ch0 sync", exp_sym, tmds.ch0);
                    assert (tmds.ch1 == SYM_00 && tmds.ch2 == SYM_00)
                        else value_error("ch1 ch2 ctrl", {SYM_00, SYM_00},
                                         {tmds.ch1, tmds.ch2});
                end
            end
            if (frame) begin
                locked  = 1'b1;
                pos_cnt = 0;
                row     = -1;
            end else begin
                pos_cnt++;
            end
            if (video) begin
                if (!prev_video) begin
                    row++;
                    col = 0;
                end else begin
                    col++;
                end
                disp[0] += $countones(tmds.ch0) - 5;    // half bit units
                disp[1] += $countones(tmds.ch1) - 5;
                disp[2] += $countones(tmds.ch2) - 5;
                if (capturing && row >= 0 && row < `GFX_FB_HEIGHT && col < `GFX_FB_WIDTH) begin
                    cap[row][col] = {tmds_decode(tmds.ch2), tmds_decode(tmds.ch1),
                                     tmds_decode(tmds.ch0)};
                end
            end else if (prev_video) begin
                for (int c = 0; c < 3; c++) begin
                    assert (disp[c] >= -8 && disp[c] <= 8)
                        else value_error($sformatf("disparity ch%0d", c), 0, disp[c]);
                    disp[c] = 0;
                end
            end
            prev_video = video;
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = cmd_q.size() * (`GFX_FB_WIDTH * `GFX_FB_HEIGHT + 64) + 3 * FRAME_CLKS;
        #(limit * 10);
        stop_run("timeout, the run did not finish in the allowed time");
    end

    initial begin
        seed       = 32'h3e8b;
        arst_n     = 1'b0;
        draw_start = 1'b0;
        cmd        = '0;
        err_count  = 0;
        done_count = 0;
        loaded     = 1'b0;
        capturing  = 1'b0;
        locked     = 1'b0;
        row        = -1;
        col        = 0;
        pos_cnt    = 0;
        prev_video = 1'b0;
        disp       = '{0, 0, 0};
        for (int y = 0; y < `GFX_FB_HEIGHT; y++) begin
            for (int x = 0; x < `GFX_FB_WIDTH; x++) begin
                cap[y][x] = 'x;
            end
        end
        load_file();
        repeat (3) @(posedge clk_100m);
        @(negedge clk_100m);
        arst_n = 1'b1;
        assert (tmds == {SYM_00, SYM_00, SYM_00})
            else value_error("reset symbols", {SYM_00, SYM_00, SYM_00}, tmds);
        assert (draw_busy === 1'b0) else value_error("reset busy", 0, draw_busy);
        foreach (cmd_q[i]) begin
            run_triangle(cmd_q[i], i);
        end
        while (!frame) @(negedge clk_100m);
        capturing = 1'b1;                   // one full frame
        @(negedge clk_100m);
        while (!frame) @(negedge clk_100m);
        capturing = 1'b0;
        foreach (chk_x[i]) begin
            assert (cap[chk_y[i]][chk_x[i]] === chk_rgb[i])
                else value_error($sformatf("pixel (%0d,%0d)", chk_x[i], chk_y[i]),
                                 chk_rgb[i], cap[chk_y[i]][chk_x[i]]);
        end
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tests/triangle_input.txt
# T x0 y0 x1 y1 x2 y2 cidx   draws a triangle in that colour index
# P x y rgb                  expected 24-bit colour after all triangles
T 2 2 12 2 2 12 8
T 8 4 20 4 8 14 c
T 25 10 40 10 25 25 b
P 4 4 ff004d
P 2 12 ff004d
P 12 2 ff004d
P 12 12 000000
P 9 5 29adff
P 10 10 29adff
P 26 11 00e436
P 31 10 00e436
P 30 17 00e436
P 24 12 000000
P 20 2 000000

//--- build.f
+incdir+common
common/gfx_pkg.sv
common/dvi_pkg.sv
src/display_timings.sv
draw/draw_line.sv
draw/draw_triangle_fill.sv
src/framebuffer.sv
dvi/tmds_encoder.sv
src/triangle_gfx_top.sv
tests/tb_triangle_gfx.sv

//--- Bender.yml
package:
  name: triangle_gfx

export_include_dirs:
  - common

sources:
  - common/gfx_pkg.sv
  - common/dvi_pkg.sv
  - src/display_timings.sv
  - draw/draw_line.sv
  - draw/draw_triangle_fill.sv
  - src/framebuffer.sv
  - dvi/tmds_encoder.sv
  - src/triangle_gfx_top.sv
  - target: test
    files:
      - tests/tb_triangle_gfx.sv
